// File: verilog/core_pkg.sv
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    // one-hot, bit 0 = add ... bit 14 = geu
    typedef logic [14:0] alu_op_t;
    // one-hot, bit 0 = jal ... bit 7 = bgeu
    typedef logic [7:0]  branch_op_t;
    // one-hot: csrrs, csrrw, ecall, mret
    typedef logic [3:0]  ecu_op_t;

    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_calc   = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam csr_addr_t csr_mstatus = 12'h300;
    localparam csr_addr_t csr_mtvec   = 12'h305;
    localparam csr_addr_t csr_mepc    = 12'h341;
    localparam csr_addr_t csr_mcause  = 12'h342;

    localparam word_t cause_ecall_m = 32'd11; // environment call from m-mode

endpackage

// File: verilog/decode_if.sv
`timescale 1ns/100ps

interface decode_if;
    import core_pkg::*;

    logic       valid;
    alu_op_t    alu_op;
    word_t      alu_src1;
    word_t      alu_src2;
    branch_op_t branch_op;
    word_t      branch_base; // pc, or rs1 for jalr
    word_t      branch_imm;
    ecu_op_t    ecu_op;
    reg_addr_t  wr_reg_des;  // zero when nothing is written
    word_t      pc;
    logic       break_ctrl;

    modport dec (
        output valid, alu_op, alu_src1, alu_src2,
        output branch_op, branch_base, branch_imm,
        output ecu_op, wr_reg_des, pc, break_ctrl
    );

    modport exe (
        input valid, alu_op, alu_src1, alu_src2,
        input branch_op, branch_base, branch_imm,
        input ecu_op, wr_reg_des, pc, break_ctrl
    );

endinterface

// File: verilog/idu.sv
`timescale 1ns/100ps

module idu (
    input  logic                inst_valid,
    input  core_pkg::word_t     inst,
    input  core_pkg::word_t     pc,
    input  core_pkg::word_t     reg_rdata1,
    input  core_pkg::word_t     reg_rdata2,
    input  core_pkg::word_t     csr_rdata,
    output core_pkg::reg_addr_t reg_raddr1,
    output core_pkg::reg_addr_t reg_raddr2,
    output core_pkg::csr_addr_t csr_raddr,
    output core_pkg::csr_addr_t csr_waddr,
    output core_pkg::word_t     ecu_wdata,
    decode_if.dec               dec
);
    import core_pkg::*;

    logic [6:0] opcode;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    csr_addr_t  csr;
    logic [7:0] f3;

    logic op_imm, op_calc, op_lui, op_auipc, op_jal, op_jalr, op_branch, op_system;
    logic is_jalr, is_ecall, is_ebreak, is_mret, is_csrrw, is_csrrs;
    logic is_sub, is_sra, is_shl, is_shr;

    alu_op_t    alu_op;
    branch_op_t branch_op;
    word_t      imm;
    logic       rd_write;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];
    assign csr    = inst[31:20];
    assign f3     = 8'b1 << funct3;

    assign op_imm    = (opcode == opc_imm);
    assign op_calc   = (opcode == opc_calc);
    assign op_lui    = (opcode == opc_lui);
    assign op_auipc  = (opcode == opc_auipc);
    assign op_jal    = (opcode == opc_jal);
    assign op_jalr   = (opcode == opc_jalr);
    assign op_branch = (opcode == opc_branch);
    assign op_system = (opcode == opc_system);

    assign is_jalr   = op_jalr & f3[0];
    assign is_ecall  = op_system & f3[0] & (rd == '0) & (csr == 12'h000);
    assign is_ebreak = op_system & f3[0] & (rd == '0) & (csr == 12'h001);
    assign is_mret   = op_system & f3[0] & (rd == '0) & (csr == 12'h302);
    assign is_csrrw  = op_system & f3[1];
    assign is_csrrs  = op_system & f3[2];

    assign is_sub = op_calc & f3[0] & funct7[5];
    assign is_shl = (op_imm | op_calc) & f3[1] & ~funct7[5];
    assign is_shr = (op_imm | op_calc) & f3[5] & ~funct7[5];
    assign is_sra = (op_imm | op_calc) & f3[5] & funct7[5];

    // one ALU op bit per instruction class
    assign alu_op[0]  = ((op_imm | op_calc) & f3[0] & ~is_sub) | op_auipc | op_jal | is_jalr;
    assign alu_op[1]  = is_sub;
    assign alu_op[2]  = ((op_imm | op_calc) & f3[2]) | (op_branch & f3[4]); // slt, blt
    assign alu_op[3]  = ((op_imm | op_calc) & f3[3]) | (op_branch & f3[6]); // sltu, bltu
    assign alu_op[4]  = (op_imm | op_calc) & f3[7];
    assign alu_op[5]  = (op_imm | op_calc) & f3[6];
    assign alu_op[6]  = (op_imm | op_calc) & f3[4];
    assign alu_op[7]  = is_shl;
    assign alu_op[8]  = is_shr;
    assign alu_op[9]  = is_sra;
    assign alu_op[10] = op_lui | is_csrrw | is_csrrs; // pass src2
    assign alu_op[11] = op_branch & f3[0];
    assign alu_op[12] = op_branch & f3[1];
    assign alu_op[13] = op_branch & f3[5];
    assign alu_op[14] = op_branch & f3[7];

    assign branch_op = {op_branch & f3[7], op_branch & f3[5], op_branch & f3[6],
                        op_branch & f3[4], op_branch & f3[1], op_branch & f3[0],
                        is_jalr, op_jal};

    // immediate by format
    assign imm = ({32{op_imm | op_jalr}} & {{20{inst[31]}}, inst[31:20]}) |
                 ({32{op_branch}} & {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0}) |
                 ({32{op_lui | op_auipc}} & {inst[31:12], 12'b0}) |
                 ({32{op_jal}} & {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0});

    assign reg_raddr1 = (op_imm | op_calc | op_branch | is_jalr | is_csrrw | is_csrrs) ? rs1 : '0;
    assign reg_raddr2 = (op_calc | op_branch) ? rs2 : '0;

    assign csr_raddr = ({12{is_csrrw | is_csrrs}} & csr) |
                       ({12{is_ecall}} & csr_mtvec) |
                       ({12{is_mret}} & csr_mepc);
    assign csr_waddr = csr;
    assign ecu_wdata = is_csrrw ? reg_rdata1 : (csr_rdata | reg_rdata1);

    assign rd_write = (|alu_op) & ~op_branch;

    assign dec.valid       = inst_valid;
    assign dec.alu_op      = alu_op;
    assign dec.alu_src1    = (op_auipc | op_jal | is_jalr) ? pc : reg_rdata1;
    assign dec.alu_src2    = (op_imm | op_lui | op_auipc) ? imm :
                             (op_jal | is_jalr)            ? 32'd4 :
                             op_system                     ? csr_rdata : reg_rdata2;
    assign dec.branch_op   = branch_op;
    assign dec.branch_base = is_jalr ? reg_rdata1 : pc;
    assign dec.branch_imm  = imm;
    assign dec.ecu_op      = {is_mret, is_ecall, is_csrrw, is_csrrs & (rs1 != '0)};
    assign dec.wr_reg_des  = rd_write ? rd : '0;
    assign dec.pc          = pc;
    assign dec.break_ctrl  = is_ebreak;

    always_comb begin
        if (inst_valid) begin
            assert ($onehot0(alu_op) && $onehot0(branch_op))
                else $error("idu: ambiguous alu_op or branch_op");
        end
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::reg_addr_t raddr1,
    input  core_pkg::reg_addr_t raddr2,
    output core_pkg::word_t     rdata1,
    output core_pkg::word_t     rdata2,
    input  logic                we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::word_t     wdata
);
    import core_pkg::*;

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: verilog/csr_file.sv
`timescale 1ns/100ps

module csr_file (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::csr_addr_t csr_raddr,
    output core_pkg::word_t     csr_rdata,
    input  logic                csr_we,
    input  core_pkg::ecu_op_t   ecu_op,
    input  core_pkg::csr_addr_t csr_waddr,
    input  core_pkg::word_t     ecu_wdata,
    input  core_pkg::word_t     epc
);
    import core_pkg::*;

    word_t mstatus;
    word_t mtvec;
    word_t mepc;
    word_t mcause;

    always_comb begin
        case (csr_raddr)
            csr_mstatus: csr_rdata = mstatus;
            csr_mtvec:   csr_rdata = mtvec;
            csr_mepc:    csr_rdata = mepc;
            csr_mcause:  csr_rdata = mcause;
            default:     csr_rdata = '0;
        endcase
    end

    // mret only redirects the pc, no state change here
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (csr_we) begin
            if (ecu_op[2]) begin
                mepc   <= epc;
                mcause <= cause_ecall_m;
            end else if (ecu_op[0] | ecu_op[1]) begin
                case (csr_waddr)
                    csr_mstatus: mstatus <= ecu_wdata;
                    csr_mtvec:   mtvec   <= ecu_wdata;
                    csr_mepc:    mepc    <= ecu_wdata;
                    csr_mcause:  mcause  <= ecu_wdata;
                    default: ; // unknown csr, write dropped
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) csr_we |-> !(ecu_op[2] && ecu_op[3]))
        else $error("csr_file: ecall and mret together");

endmodule

// File: verilog/exu.sv
`timescale 1ns/100ps

module exu #(
    parameter core_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic                clk,
    input  logic                rst,
    decode_if.exe               dec,
    output core_pkg::word_t     pc,
    output logic                reg_we,
    output core_pkg::reg_addr_t reg_waddr,
    output core_pkg::word_t     reg_wdata,
    output logic                csr_we,
    input  core_pkg::word_t     csr_rdata,
    output logic                commit_valid,
    output logic                commit_wen,
    output core_pkg::reg_addr_t commit_rd,
    output core_pkg::word_t     commit_data,
    output logic                halted
);
    import core_pkg::*;

    word_t a;
    word_t b;
    word_t alu_res;
    word_t target_sum;
    word_t next_pc;
    logic  taken;
    logic  accept;

    assign a = dec.alu_src1;
    assign b = dec.alu_src2;

    always_comb begin
        case (1'b1)
            dec.alu_op[0]:  alu_res = a + b;
            dec.alu_op[1]:  alu_res = a - b;
            dec.alu_op[2]:  alu_res = word_t'($signed(a) < $signed(b));
            dec.alu_op[3]:  alu_res = word_t'(a < b);
            dec.alu_op[4]:  alu_res = a & b;
            dec.alu_op[5]:  alu_res = a | b;
            dec.alu_op[6]:  alu_res = a ^ b;
            dec.alu_op[7]:  alu_res = a << b[4:0];
            dec.alu_op[8]:  alu_res = a >> b[4:0];
            dec.alu_op[9]:  alu_res = $signed(a) >>> b[4:0];
            dec.alu_op[10]: alu_res = b;
            dec.alu_op[11]: alu_res = word_t'(a == b);
            dec.alu_op[12]: alu_res = word_t'(a != b);
            dec.alu_op[13]: alu_res = word_t'($signed(a) >= $signed(b));
            dec.alu_op[14]: alu_res = word_t'(a >= b);
            default:        alu_res = '0;
        endcase
    end

    // jumps always taken, branches on the compare bit
    assign taken      = dec.branch_op[0] | dec.branch_op[1] |
                        ((|dec.branch_op[7:2]) & alu_res[0]);
    assign target_sum = dec.branch_base + dec.branch_imm;

    assign next_pc = (dec.ecu_op[2] | dec.ecu_op[3]) ? csr_rdata :  // mtvec or mepc
                     taken ? {target_sum[31:1], 1'b0} : dec.pc + 32'd4;

    assign accept    = dec.valid & ~halted;
    assign reg_we    = accept & (dec.wr_reg_des != '0);
    assign reg_waddr = dec.wr_reg_des;
    assign reg_wdata = alu_res;
    assign csr_we    = accept & (|dec.ecu_op);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= reset_pc;
            commit_valid <= 1'b0;
            commit_wen   <= 1'b0;
            halted       <= 1'b0;
        end else begin
            commit_valid <= accept;
            commit_wen   <= reg_we;
            if (accept) begin
                pc <= next_pc;
                if (dec.break_ctrl) begin
                    halted <= 1'b1; // sticky until reset
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            commit_rd   <= dec.wr_reg_des;
            commit_data <= alu_res;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !dec.valid |=> !commit_valid)
        else $error("exu: commit without a strobe");

endmodule

// File: verilog/exec_core.sv
`timescale 1ns/100ps

module exec_core #(
    parameter core_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid,
    input  core_pkg::word_t     inst,
    output core_pkg::word_t     pc,
    output logic                commit_valid,
    output logic                commit_wen,
    output core_pkg::reg_addr_t commit_rd,
    output core_pkg::word_t     commit_data,
    output logic                halted
);
    import core_pkg::*;

    reg_addr_t reg_raddr1;
    reg_addr_t reg_raddr2;
    word_t     reg_rdata1;
    word_t     reg_rdata2;
    logic      reg_we;
    reg_addr_t reg_waddr;
    word_t     reg_wdata;
    csr_addr_t csr_raddr;
    csr_addr_t csr_waddr;
    word_t     csr_rdata;
    word_t     ecu_wdata;
    logic      csr_we;

    decode_if dec_bus ();

    idu idu_inst (
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .reg_rdata1 (reg_rdata1),
        .reg_rdata2 (reg_rdata2),
        .csr_rdata  (csr_rdata),
        .reg_raddr1 (reg_raddr1),
        .reg_raddr2 (reg_raddr2),
        .csr_raddr  (csr_raddr),
        .csr_waddr  (csr_waddr),
        .ecu_wdata  (ecu_wdata),
        .dec        (dec_bus.dec)
    );

    regfile regfile_inst (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (reg_raddr1),
        .raddr2 (reg_raddr2),
        .rdata1 (reg_rdata1),
        .rdata2 (reg_rdata2),
        .we     (reg_we),
        .waddr  (reg_waddr),
        .wdata  (reg_wdata)
    );

    csr_file csr_file_inst (
        .clk       (clk),
        .rst       (rst),
        .csr_raddr (csr_raddr),
        .csr_rdata (csr_rdata),
        .csr_we    (csr_we),
        .ecu_op    (dec_bus.ecu_op),
        .csr_waddr (csr_waddr),
        .ecu_wdata (ecu_wdata),
        .epc       (dec_bus.pc)  // pc of the ecall
    );

    exu #(
        .reset_pc (reset_pc)
    ) exu_inst (
        .clk          (clk),
        .rst          (rst),
        .dec          (dec_bus.exe),
        .pc           (pc),
        .reg_we       (reg_we),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .csr_we       (csr_we),
        .csr_rdata    (csr_rdata),
        .commit_valid (commit_valid),
        .commit_wen   (commit_wen),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .halted       (halted)
    );

endmodule

// File: sim/tb_exec_core.sv
`timescale 1ns/100ps

module tb_exec_core;
    import core_pkg::*;

    localparam word_t reset_pc = 32'h8000_0000;

    typedef struct packed {
        word_t     inst;
        logic      gap;    // idle cycle before the strobe
        logic      commit; // commit_valid expected
        logic      wen;
        reg_addr_t rd;
        word_t     data;
        word_t     npc;
    } row_t;

    logic      clk;
    logic      rst;
    logic      inst_valid;
    word_t     inst;
    word_t     pc;
    logic      commit_valid;
    logic      commit_wen;
    reg_addr_t commit_rd;
    word_t     commit_data;
    logic      halted;

    row_t   rows[$];
    integer seed;
    word_t  next_pc;      // pc while the table is built
    word_t  exp_pc;
    int     drv_old = -1; // row strobed two edges ago, -1 for idle
    int     drv_new = -1;
    int     cycles = 0;

    exec_core #(
        .reset_pc (reset_pc)
    ) exec_core_inst (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .commit_valid (commit_valid),
        .commit_wen   (commit_wen),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 4 * rows.size() + 40) begin
            $display("Test failures found");
            $fatal(1, "timeout after %0d cycles, the table did not finish", cycles);
        end
    end

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic word_t r_format(input logic [6:0] f7, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input logic [2:0] f3,
                                       input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, opc_calc};
    endfunction

    function automatic word_t i_format(input logic [11:0] imm, input reg_addr_t rs1,
                                       input logic [2:0] f3, input reg_addr_t rd,
                                       input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t u_format(input logic [19:0] imm, input reg_addr_t rd,
                                       input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t b_format(input logic [12:0] off, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic word_t j_format(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    task automatic push_row(input word_t i, input logic commit, input logic wen,
                            input reg_addr_t rd, input word_t data, input word_t npc);
        row_t r;
        r.inst   = i;
        r.gap    = (($random(seed) & 3) == 0);
        r.commit = commit;
        r.wen    = wen;
        r.rd     = rd;
        r.data   = data;
        r.npc    = npc;
        rows.push_back(r);
        next_pc = npc;
    endtask

    task automatic expect_write(input word_t i, input reg_addr_t rd, input word_t data);
        push_row(i, 1'b1, 1'b1, rd, data, next_pc + 32'd4);
    endtask

    task automatic expect_no_write(input word_t i, input word_t npc);
        push_row(i, 1'b1, 1'b0, 5'd0, 32'd0, npc);
    endtask

    task automatic build_table;
        expect_write(i_format(12'd5, 5'd0, 3'd0, 5'd1, opc_imm), 5'd1, 32'd5);
        expect_write(i_format(12'hFFD, 5'd0, 3'd0, 5'd2, opc_imm), 5'd2, 32'hFFFF_FFFD);
        expect_write(r_format(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 5'd3, 32'd2);
        expect_write(r_format(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), 5'd4, 32'd8);
        expect_write(r_format(7'h00, 5'd2, 5'd1, 3'd7, 5'd5), 5'd5, 32'd5);
        expect_write(r_format(7'h00, 5'd2, 5'd1, 3'd6, 5'd6), 5'd6, 32'hFFFF_FFFD);
        expect_write(r_format(7'h00, 5'd2, 5'd1, 3'd4, 5'd7), 5'd7, 32'hFFFF_FFF8);
        expect_write(r_format(7'h00, 5'd1, 5'd2, 3'd2, 5'd8), 5'd8, 32'd1);
        expect_write(r_format(7'h00, 5'd1, 5'd2, 3'd3, 5'd9), 5'd9, 32'd0);
        expect_write(i_format(12'h004, 5'd1, 3'd1, 5'd10, opc_imm), 5'd10, 32'h50);
        expect_write(i_format(12'h01C, 5'd2, 3'd5, 5'd11, opc_imm), 5'd11, 32'hF);
        expect_write(i_format(12'h401, 5'd2, 3'd5, 5'd12, opc_imm), 5'd12, 32'hFFFF_FFFE);
        expect_write(r_format(7'h00, 5'd1, 5'd1, 3'd1, 5'd13), 5'd13, 32'hA0);
        expect_write(r_format(7'h00, 5'd1, 5'd2, 3'd5, 5'd14), 5'd14, 32'h07FF_FFFF);
        expect_write(r_format(7'h20, 5'd1, 5'd2, 3'd5, 5'd15), 5'd15, 32'hFFFF_FFFF);
        expect_write(i_format(12'd6, 5'd1, 3'd2, 5'd16, opc_imm), 5'd16, 32'd1);
        expect_write(i_format(12'hFFF, 5'd1, 3'd3, 5'd17, opc_imm), 5'd17, 32'd1);
        expect_write(i_format(12'h0FF, 5'd1, 3'd4, 5'd18, opc_imm), 5'd18, 32'hFA);
        expect_write(i_format(12'h030, 5'd1, 3'd6, 5'd19, opc_imm), 5'd19, 32'h35);
        expect_write(i_format(12'h00F, 5'd2, 3'd7, 5'd20, opc_imm), 5'd20, 32'hD);
        expect_write(u_format(20'h12345, 5'd21, opc_lui), 5'd21, 32'h1234_5000);
        expect_write(u_format(20'h00001, 5'd22, opc_auipc), 5'd22, 32'h8000_1054);
        expect_no_write(i_format(12'd7, 5'd1, 3'd0, 5'd0, opc_imm), 32'h8000_005C);
        expect_write(r_format(7'h00, 5'd1, 5'd0, 3'd0, 5'd23), 5'd23, 32'd5); // x0 still 0
        // branches, taken then not taken
        expect_no_write(b_format(13'd8, 5'd1, 5'd1, 3'd0), 32'h8000_0068);
        expect_no_write(b_format(13'd8, 5'd2, 5'd1, 3'd0), 32'h8000_006C);
        expect_no_write(b_format(13'd12, 5'd2, 5'd1, 3'd1), 32'h8000_0078);
        expect_no_write(b_format(13'd12, 5'd1, 5'd1, 3'd1), 32'h8000_007C);
        expect_no_write(b_format(13'h1FF8, 5'd1, 5'd2, 3'd4), 32'h8000_0074);
        expect_no_write(b_format(13'd8, 5'd2, 5'd1, 3'd4), 32'h8000_0078);
        expect_no_write(b_format(13'd16, 5'd2, 5'd1, 3'd6), 32'h8000_0088);
        expect_no_write(b_format(13'd16, 5'd1, 5'd2, 3'd6), 32'h8000_008C);
        expect_no_write(b_format(13'd20, 5'd2, 5'd1, 3'd5), 32'h8000_00A0);
        expect_no_write(b_format(13'd20, 5'd1, 5'd2, 3'd5), 32'h8000_00A4);
        expect_no_write(b_format(13'd24, 5'd1, 5'd2, 3'd7), 32'h8000_00BC);
        expect_no_write(b_format(13'd24, 5'd2, 5'd1, 3'd7), 32'h8000_00C0);
        push_row(j_format(21'h100, 5'd24), 1'b1, 1'b1, 5'd24, 32'h8000_00C4, 32'h8000_01C0);
        push_row(i_format(12'h00D, 5'd22, 3'd0, 5'd25, opc_jalr), 1'b1, 1'b1, 5'd25,
                 32'h8000_01C4, 32'h8000_1060); // bit 0 of target dropped
        // csr access
        expect_write(u_format(20'h80002, 5'd27, opc_lui), 5'd27, 32'h8000_2000);
        expect_write(i_format(csr_mtvec, 5'd27, 3'd1, 5'd26, opc_system), 5'd26, 32'd0);
        expect_write(i_format(csr_mtvec, 5'd0, 3'd2, 5'd28, opc_system), 5'd28, 32'h8000_2000);
        expect_write(i_format(csr_mstatus, 5'd1, 3'd2, 5'd29, opc_system), 5'd29, 32'd0);
        expect_write(i_format(csr_mstatus, 5'd19, 3'd2, 5'd30, opc_system), 5'd30, 32'd5);
        expect_write(i_format(csr_mstatus, 5'd0, 3'd2, 5'd31, opc_system), 5'd31, 32'h35);
        expect_write(i_format(csr_mstatus, 5'd0, 3'd2, 5'd31, opc_system), 5'd31, 32'h35);
        // trap entry at 0x8000_107c, then return
        expect_no_write(32'h0000_0073, 32'h8000_2000);
        expect_write(i_format(csr_mepc, 5'd0, 3'd2, 5'd5, opc_system), 5'd5, 32'h8000_107C);
        expect_write(i_format(csr_mcause, 5'd0, 3'd2, 5'd6, opc_system), 5'd6, 32'd11);
        expect_no_write(32'h3020_0073, 32'h8000_107C);
        expect_no_write(i_format(12'd0, 5'd1, 3'd2, 5'd7, opc_load), 32'h8000_1080);
        expect_no_write(32'h0010_0073, 32'h8000_1084); // ebreak
        push_row(i_format(12'd1, 5'd0, 3'd0, 5'd1, opc_imm), 1'b0, 1'b0, 5'd0, 32'd0,
                 32'h8000_1084); // ignored while halted
    endtask

    // one edge: check the commit of the strobe two edges back, then drive
    task automatic clock_step(input int idx);
        row_t r;
        @(posedge clk);
        if (drv_old < 0) begin
            compare("commit_valid", 32'(commit_valid), 32'd0);
        end else begin
            r = rows[drv_old];
            compare("commit_valid", 32'(commit_valid), 32'(r.commit));
            if (r.commit) begin
                compare("commit_wen", 32'(commit_wen), 32'(r.wen));
                compare("commit_rd", 32'(commit_rd), 32'(r.rd));
                if (r.wen) begin
                    compare("commit_data", commit_data, r.data);
                end
            end
            exp_pc = r.npc;
        end
        compare("pc", pc, exp_pc);
        drv_old = drv_new;
        drv_new = idx;
        if (idx >= 0) begin
            inst_valid <= 1'b1;
            inst       <= rows[idx].inst;
        end else begin
            inst_valid <= 1'b0;
        end
    endtask

    initial begin
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        seed       = 32'h2179_042e;
        next_pc    = reset_pc;
        exp_pc     = reset_pc;
        build_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        compare("pc", pc, reset_pc);
        compare("commit_valid", 32'(commit_valid), 32'd0);
        compare("halted", 32'(halted), 32'd0);
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].gap) begin
                clock_step(-1);
            end
            clock_step(i);
        end
        clock_step(-1); // drain the last two rows
        clock_step(-1);
        compare("halted", 32'(halted), 32'd1);
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: sources.f
verilog/core_pkg.sv
verilog/decode_if.sv
verilog/idu.sv
verilog/regfile.sv
verilog/csr_file.sv
verilog/exu.sv
verilog/exec_core.sv
sim/tb_exec_core.sv

// File: Makefile
SRCS := $(shell cat sources.f)

.PHONY: all run clean

all: obj_dir/Vtb_exec_core

obj_dir/Vtb_exec_core: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_exec_core -f sources.f

run: obj_dir/Vtb_exec_core
	./obj_dir/Vtb_exec_core

clean:
	rm -rf obj_dir
